//--- verilog/isaPkg.sv
package isaPkg;

	localparam int regAddrWidth = 5;
	localparam int wordWidth = 32;

	//////////////////////////////////////////////////
	// Opcodes
	localparam logic [5:0] opRtype = 6'h00;
	localparam logic [5:0] opJal = 6'h03;
	localparam logic [5:0] opBeq = 6'h04;
	localparam logic [5:0] opBne = 6'h05;
	localparam logic [5:0] opAddi = 6'h08;
	localparam logic [5:0] opAndi = 6'h0c;
	localparam logic [5:0] opOri = 6'h0d;
	localparam logic [5:0] opLui = 6'h0f;
	localparam logic [5:0] opLw = 6'h23;
	localparam logic [5:0] opSw = 6'h2b;

	//////////////////////////////////////////////////
	// R-type function codes
	localparam logic [5:0] fnJr = 6'h08;
	localparam logic [5:0] fnAdd = 6'h20;
	localparam logic [5:0] fnSub = 6'h22;
	localparam logic [5:0] fnAnd = 6'h24;
	localparam logic [5:0] fnOr = 6'h25;
	localparam logic [5:0] fnSlt = 6'h2a;
	localparam logic [5:0] fnSltu = 6'h2b;

	localparam logic [regAddrWidth-1:0] linkReg = 5'd31; // Written by jal

	// One fetched word, two views
	typedef union packed {
		struct packed {
			logic [5:0] opcode;
			logic [regAddrWidth-1:0] rs;
			logic [regAddrWidth-1:0] rt;
			logic [regAddrWidth-1:0] rd;
			logic [4:0] shamt;
			logic [5:0] funct;
		} r;
		struct packed {
			logic [5:0] opcode;
			logic [regAddrWidth-1:0] rs;
			logic [regAddrWidth-1:0] rt;
			logic [15:0] imm16;
		} i;
	} instrWord_t;

endpackage

//--- verilog/pipePkg.sv
package pipePkg;

	localparam logic [31:0] resetPc = 32'h0000_3000;

	localparam int tNewWidth = 2;

	// Cycles until a producer's result can be forwarded
	localparam logic [tNewWidth-1:0] tNewNow = 2'd0;
	localparam logic [tNewWidth-1:0] tNewAlu = 2'd1;
	localparam logic [tNewWidth-1:0] tNewLoad = 2'd2;

	// Cycles until a consumer needs its operand, counted from decode
	localparam logic [tNewWidth-1:0] tUseBranch = 2'd0;
	localparam logic [tNewWidth-1:0] tUseAlu = 2'd1;
	localparam logic [tNewWidth-1:0] tUseStore = 2'd2;

	typedef enum logic [3:0] {
		aluAdd,
		aluSub,
		aluAnd,
		aluOr,
		aluSlt,
		aluSltu,
		aluLui
	} aluOp_t;

endpackage

//--- verilog/stageIf.sv
`timescale 1ns/1ps

// Decode to execute
interface decExIf;
	isaPkg::instrWord_t instr;
	logic [isaPkg::wordWidth-1:0] pc;
	logic [isaPkg::wordWidth-1:0] v1;
	logic [isaPkg::wordWidth-1:0] v2;
	logic [isaPkg::regAddrWidth-1:0] newAddr;
	logic [pipePkg::tNewWidth-1:0] newT;
	logic [isaPkg::wordWidth-1:0] newValue;

	modport source(output instr, pc, v1, v2, newAddr, newT, newValue);
	modport sink(input instr, pc, v1, v2, newAddr, newT, newValue);
endinterface

// Execute to memory/writeback
interface exResIf;
	isaPkg::instrWord_t instr;
	logic [isaPkg::wordWidth-1:0] pc;
	logic [isaPkg::wordWidth-1:0] aluResult;
	logic [isaPkg::wordWidth-1:0] storeData;
	logic [isaPkg::regAddrWidth-1:0] newAddr;
	logic [pipePkg::tNewWidth-1:0] newT;
	logic [isaPkg::wordWidth-1:0] newValue;

	modport source(output instr, pc, aluResult, storeData, newAddr, newT, newValue);
	modport sink(input instr, pc, aluResult, storeData, newAddr, newT, newValue);
endinterface

// Producer records fed back for stall and forwarding
interface fwdIf;
	logic [isaPkg::regAddrWidth-1:0] e2mAddr;
	logic [pipePkg::tNewWidth-1:0] e2mT;
	logic [isaPkg::wordWidth-1:0] e2mValue;
	logic [isaPkg::regAddrWidth-1:0] m2wAddr;
	logic [pipePkg::tNewWidth-1:0] m2wT;
	logic [isaPkg::wordWidth-1:0] m2wValue;

	modport execSrc(output e2mAddr, e2mT, e2mValue);
	modport resultSrc(output m2wAddr, m2wT, m2wValue);
	modport user(input e2mAddr, e2mT, e2mValue, m2wAddr, m2wT, m2wValue);
endinterface

//--- verilog/regFile.sv
`timescale 1ns/1ps

module regFile (
	input logic clk,
	input logic reset,
	input logic [isaPkg::regAddrWidth-1:0] readAddr1,
	input logic [isaPkg::regAddrWidth-1:0] readAddr2,
	output logic [isaPkg::wordWidth-1:0] readData1,
	output logic [isaPkg::wordWidth-1:0] readData2,
	input logic writeEn,
	input logic [isaPkg::regAddrWidth-1:0] writeAddr,
	input logic [isaPkg::wordWidth-1:0] writeData
);
	import isaPkg::*;

	logic [wordWidth-1:0] regs [2**regAddrWidth];

	always_ff @(posedge clk) begin
		if (reset) begin
			for (int i = 0; i < 2**regAddrWidth; i++) begin
				regs[i] <= '0;
			end
		end else if (writeEn) begin
			regs[writeAddr] <= writeData;
		end
	end

	// r0 is hardwired
	assign readData1 = (readAddr1 == '0) ? '0 : regs[readAddr1];
	assign readData2 = (readAddr2 == '0) ? '0 : regs[readAddr2];

	// Writeback filters out destination 0 upstream
	assert property (@(posedge clk) disable iff (reset) writeEn |-> writeAddr != '0)
		else $error("Register file write to r0");

endmodule

//--- verilog/decodeStage.sv
`timescale 1ns/1ps

module decodeStage (
	input logic clk,
	input logic reset,
	output logic [isaPkg::wordWidth-1:0] instAddr,
	input logic [isaPkg::wordWidth-1:0] instData,
	output logic [isaPkg::regAddrWidth-1:0] readAddr1,
	output logic [isaPkg::regAddrWidth-1:0] readAddr2,
	input logic [isaPkg::wordWidth-1:0] readData1,
	input logic [isaPkg::wordWidth-1:0] readData2,
	decExIf.source dec,
	fwdIf.user fwd
);
	import isaPkg::*;
	import pipePkg::*;

	logic [wordWidth-1:0] pc;
	logic [wordWidth-1:0] nextPc;
	logic [wordWidth-1:0] fdPc;
	instrWord_t fdInstr;
	logic isRtype, isAluR, isJr, isImmAlu, isLw, isSw, isBeq, isBne, isLui, isJal;
	logic use1, use2;
	logic [tNewWidth-1:0] tUse1, tUse2;
	logic [regAddrWidth-1:0] newAddr;
	logic [tNewWidth-1:0] newT;
	logic [wordWidth-1:0] newValue;
	logic [wordWidth-1:0] v1, v2;
	logic stall;
	logic jumpEn;
	logic [wordWidth-1:0] jumpTarget;
	logic [wordWidth-1:0] branchOffset;
	logic [25:0] jumpIndex;

	// Youngest producer first, r0 never matches
	function automatic logic mustWait(input logic [regAddrWidth-1:0] addr, input logic used,
			input logic [tNewWidth-1:0] tUse);
		if (!used || addr == '0)
			return 1'b0;
		if (addr == dec.newAddr)
			return tUse < dec.newT;
		if (addr == fwd.e2mAddr)
			return tUse < fwd.e2mT;
		if (addr == fwd.m2wAddr)
			return tUse < fwd.m2wT;
		return 1'b0;
	endfunction

	function automatic logic [wordWidth-1:0] forward(input logic [regAddrWidth-1:0] addr,
			input logic [wordWidth-1:0] grf);
		if (addr == '0)
			return grf;
		if (addr == dec.newAddr)
			return (dec.newT == '0) ? dec.newValue : grf;
		if (addr == fwd.e2mAddr)
			return (fwd.e2mT == '0) ? fwd.e2mValue : grf;
		if (addr == fwd.m2wAddr)
			return (fwd.m2wT == '0) ? fwd.m2wValue : grf;
		return grf;
	endfunction

	//////////////////////////////////////////////////
	// Fetch and F/D register
	always_ff @(posedge clk) begin
		if (reset) begin
			pc <= resetPc;
			fdInstr <= '0;
		end else if (!stall) begin
			pc <= nextPc;
			fdInstr <= instData;
		end
	end

	always_ff @(posedge clk) begin
		if (!stall)
			fdPc <= pc;
	end

	assign instAddr = pc;

	//////////////////////////////////////////////////
	// Decode
	assign isRtype = fdInstr.r.opcode == opRtype;
	assign isAluR = isRtype && (fdInstr.r.funct inside {fnAdd, fnSub, fnAnd, fnOr, fnSlt, fnSltu});
	assign isJr = isRtype && fdInstr.r.funct == fnJr;
	assign isImmAlu = fdInstr.i.opcode inside {opAddi, opAndi, opOri};
	assign isLw = fdInstr.i.opcode == opLw;
	assign isSw = fdInstr.i.opcode == opSw;
	assign isBeq = fdInstr.i.opcode == opBeq;
	assign isBne = fdInstr.i.opcode == opBne;
	assign isLui = fdInstr.i.opcode == opLui;
	assign isJal = fdInstr.i.opcode == opJal;

	always_comb begin // Operand use times
		use1 = isAluR || isJr || isImmAlu || isLw || isSw || isBeq || isBne;
		use2 = isAluR || isSw || isBeq || isBne;
		tUse1 = (isJr || isBeq || isBne) ? tUseBranch : tUseAlu;
		tUse2 = isSw ? tUseStore : ((isBeq || isBne) ? tUseBranch : tUseAlu);
	end

	always_comb begin // Destination record
		newAddr = '0;
		newT = tNewNow;
		newValue = '0;
		if (isAluR) begin
			newAddr = fdInstr.r.rd;
			newT = tNewAlu;
		end else if (isImmAlu) begin
			newAddr = fdInstr.i.rt;
			newT = tNewAlu;
		end else if (isLw) begin
			newAddr = fdInstr.i.rt;
			newT = tNewLoad;
		end else if (isLui) begin
			newAddr = fdInstr.i.rt;
			newValue = {fdInstr.i.imm16, 16'b0};
		end else if (isJal) begin
			newAddr = linkReg;
			newValue = fdPc + 32'd8;
		end
	end

	assign readAddr1 = fdInstr.r.rs;
	assign readAddr2 = fdInstr.r.rt;
	assign v1 = forward(fdInstr.r.rs, readData1);
	assign v2 = forward(fdInstr.r.rt, readData2);
	assign stall = mustWait(fdInstr.r.rs, use1, tUse1) || mustWait(fdInstr.r.rt, use2, tUse2);

	//////////////////////////////////////////////////
	// Branches, relative to the delay slot address
	assign branchOffset = {{14{fdInstr.i.imm16[15]}}, fdInstr.i.imm16, 2'b00};
	assign jumpIndex = {fdInstr.r.rs, fdInstr.r.rt, fdInstr.r.rd, fdInstr.r.shamt, fdInstr.r.funct};

	always_comb begin
		jumpEn = (isBeq && v1 == v2) || (isBne && v1 != v2) || isJal || isJr;
		if (isJr)
			jumpTarget = v1;
		else if (isJal)
			jumpTarget = {pc[31:28], jumpIndex, 2'b00};
		else
			jumpTarget = pc + branchOffset;
	end

	assign nextPc = jumpEn ? jumpTarget : pc + 32'd4;

	//////////////////////////////////////////////////
	// D/E register, bubble on stall
	always_ff @(posedge clk) begin
		if (reset || stall) begin
			dec.instr <= '0;
			dec.newAddr <= '0;
			dec.newT <= '0;
		end else begin
			dec.instr <= fdInstr;
			dec.newAddr <= newAddr;
			dec.newT <= newT;
		end
	end

	always_ff @(posedge clk) begin
		dec.pc <= fdPc;
		dec.v1 <= v1;
		dec.v2 <= v2;
		dec.newValue <= newValue;
	end

	// Worst case is a load feeding a branch
	assert property (@(posedge clk) disable iff (reset) stall ##1 stall |=> !stall)
		else $error("Stall held for more than two cycles");

endmodule

//--- verilog/executeStage.sv
`timescale 1ns/1ps

module executeStage (
	input logic clk,
	input logic reset,
	decExIf.sink dec,
	exResIf.source res,
	fwdIf.execSrc fwdOut,
	fwdIf.user fwd
);
	import isaPkg::*;
	import pipePkg::*;

	logic [wordWidth-1:0] v1, v2;
	logic [wordWidth-1:0] immExt;
	logic [wordWidth-1:0] srcB;
	logic [wordWidth-1:0] aluResult;
	aluOp_t aluOp;
	logic useImm;
	logic isAlu; // Result comes from the ALU

	function automatic logic [wordWidth-1:0] forward(input logic [regAddrWidth-1:0] addr,
			input logic [wordWidth-1:0] base);
		if (addr == '0)
			return base;
		if (addr == fwd.e2mAddr)
			return (fwd.e2mT == '0) ? fwd.e2mValue : base;
		if (addr == fwd.m2wAddr)
			return (fwd.m2wT == '0) ? fwd.m2wValue : base;
		return base;
	endfunction

	assign v1 = forward(dec.instr.r.rs, dec.v1);
	assign v2 = forward(dec.instr.r.rt, dec.v2);

	always_comb begin
		aluOp = aluAdd;
		useImm = 1'b1;
		isAlu = 1'b1;
		immExt = {{16{dec.instr.i.imm16[15]}}, dec.instr.i.imm16};
		case (dec.instr.i.opcode)
			opRtype: begin
				useImm = 1'b0;
				case (dec.instr.r.funct)
					fnAdd: aluOp = aluAdd;
					fnSub: aluOp = aluSub;
					fnAnd: aluOp = aluAnd;
					fnOr: aluOp = aluOr;
					fnSlt: aluOp = aluSlt;
					fnSltu: aluOp = aluSltu;
					default: isAlu = 1'b0; // jr and nops
				endcase
			end
			opAddi: aluOp = aluAdd;
			opAndi: begin
				aluOp = aluAnd;
				immExt = {16'b0, dec.instr.i.imm16};
			end
			opOri: begin
				aluOp = aluOr;
				immExt = {16'b0, dec.instr.i.imm16};
			end
			opLui: aluOp = aluLui;
			default: isAlu = 1'b0; // lw and sw only need the address
		endcase
	end

	assign srcB = useImm ? immExt : v2;

	always_comb begin
		case (aluOp)
			aluAdd: aluResult = v1 + srcB; // Wraps
			aluSub: aluResult = v1 - srcB;
			aluAnd: aluResult = v1 & srcB;
			aluOr: aluResult = v1 | srcB;
			aluSlt: aluResult = {{(wordWidth-1){1'b0}}, $signed(v1) < $signed(srcB)};
			aluSltu: aluResult = {{(wordWidth-1){1'b0}}, v1 < srcB};
			aluLui: aluResult = {dec.instr.i.imm16, 16'b0};
			default: aluResult = '0;
		endcase
	end

	//////////////////////////////////////////////////
	// E/M register
	always_ff @(posedge clk) begin
		if (reset) begin
			res.instr <= '0;
			res.newAddr <= '0;
			res.newT <= '0;
		end else begin
			res.instr <= dec.instr;
			res.newAddr <= dec.newAddr;
			res.newT <= (dec.newT != '0) ? dec.newT - 1'b1 : '0;
		end
	end

	always_ff @(posedge clk) begin
		res.pc <= dec.pc;
		res.aluResult <= aluResult;
		res.storeData <= v2;
		res.newValue <= isAlu ? aluResult : dec.newValue;
	end

	assign fwdOut.e2mAddr = res.newAddr;
	assign fwdOut.e2mT = res.newT;
	assign fwdOut.e2mValue = res.newValue;

endmodule

//--- verilog/resultStage.sv
`timescale 1ns/1ps

module resultStage (
	input logic clk,
	input logic reset,
	exResIf.sink res,
	fwdIf.resultSrc fwd,
	output logic [isaPkg::wordWidth-1:0] dataAddr,
	output logic [isaPkg::wordWidth-1:0] dataWdata,
	output logic dataWe,
	input logic [isaPkg::wordWidth-1:0] dataRdata,
	output logic grfWe,
	output logic [isaPkg::regAddrWidth-1:0] grfAddr,
	output logic [isaPkg::wordWidth-1:0] grfWdata,
	output logic [isaPkg::wordWidth-1:0] wbPc
);
	import isaPkg::*;
	import pipePkg::*;

	logic isLw, isSw;
	logic [wordWidth-1:0] storeFwd;
	logic [wordWidth-1:0] memValue;
	logic [regAddrWidth-1:0] mwAddr;
	logic [tNewWidth-1:0] mwT;
	logic [wordWidth-1:0] mwValue;
	logic [wordWidth-1:0] mwPc;

	assign isLw = res.instr.i.opcode == opLw;
	assign isSw = res.instr.i.opcode == opSw;

	// Load followed by a store of the loaded register
	always_comb begin
		storeFwd = res.storeData;
		if (res.instr.i.rt != '0 && res.instr.i.rt == mwAddr && mwT == '0)
			storeFwd = mwValue;
	end

	//////////////////////////////////////////////////
	// Data memory port
	assign dataAddr = res.aluResult;
	assign dataWdata = storeFwd;
	assign dataWe = isSw;

	assign memValue = isLw ? dataRdata : res.newValue;

	// M/W register
	always_ff @(posedge clk) begin
		if (reset) begin
			mwAddr <= '0;
			mwT <= '0;
		end else begin
			mwAddr <= res.newAddr;
			mwT <= (res.newT != '0) ? res.newT - 1'b1 : '0;
		end
	end

	always_ff @(posedge clk) begin
		mwValue <= memValue;
		mwPc <= res.pc;
	end

	assign fwd.m2wAddr = mwAddr;
	assign fwd.m2wT = mwT;
	assign fwd.m2wValue = mwValue;

	//////////////////////////////////////////////////
	// Writeback
	assign grfWe = mwAddr != '0; // No destination means r0
	assign grfAddr = mwAddr;
	assign grfWdata = mwValue;
	assign wbPc = mwPc;

	assert property (@(posedge clk) disable iff (reset) dataWe |-> dataAddr[1:0] == 2'b00)
		else $error("Unaligned store address %h", dataAddr);

endmodule

//--- verilog/mipsCore.sv
`timescale 1ns/1ps

module mipsCore (
	input logic clk,
	input logic reset,
	output logic [isaPkg::wordWidth-1:0] instAddr,
	input logic [isaPkg::wordWidth-1:0] instData,
	output logic [isaPkg::wordWidth-1:0] dataAddr,
	output logic [isaPkg::wordWidth-1:0] dataWdata,
	output logic dataWe,
	input logic [isaPkg::wordWidth-1:0] dataRdata,
	output logic grfWe,
	output logic [isaPkg::regAddrWidth-1:0] grfAddr,
	output logic [isaPkg::wordWidth-1:0] grfWdata,
	output logic [isaPkg::wordWidth-1:0] wbPc
);
	import isaPkg::*;

	logic [regAddrWidth-1:0] readAddr1, readAddr2;
	logic [wordWidth-1:0] readData1, readData2;

	decExIf i_decEx ();
	exResIf i_exRes ();
	fwdIf i_fwd ();

	regFile i_regFile (
		.clk,
		.reset,
		.readAddr1,
		.readAddr2,
		.readData1,
		.readData2,
		.writeEn(grfWe),
		.writeAddr(grfAddr),
		.writeData(grfWdata)
	);

	decodeStage i_decodeStage (
		.clk,
		.reset,
		.instAddr,
		.instData,
		.readAddr1,
		.readAddr2,
		.readData1,
		.readData2,
		.dec(i_decEx),
		.fwd(i_fwd)
	);

	// Same fwdIf seen as producer and as consumer
	executeStage i_executeStage (
		.clk,
		.reset,
		.dec(i_decEx),
		.res(i_exRes),
		.fwdOut(i_fwd),
		.fwd(i_fwd)
	);

	resultStage i_resultStage (
		.clk,
		.reset,
		.res(i_exRes),
		.fwd(i_fwd),
		.dataAddr,
		.dataWdata,
		.dataWe,
		.dataRdata,
		.grfWe,
		.grfAddr,
		.grfWdata,
		.wbPc
	);

endmodule

//--- testbench/memModel.sv
`timescale 1ns/1ps

module memModel (
	input logic clk,
	input logic [31:0] instAddr,
	output logic [31:0] instData,
	input logic [31:0] dataAddr,
	input logic [31:0] dataWdata,
	input logic dataWe,
	output logic [31:0] dataRdata
);
	import pipePkg::*;

	localparam int romWords = 256;
	localparam int ramWords = 1024;

	logic [31:0] rom [romWords];
	logic [31:0] ram [ramWords];
	logic [31:0] romIndex;

	initial begin
		for (int i = 0; i < romWords; i++)
			rom[i] = '0;
		for (int i = 0; i < ramWords; i++)
			ram[i] = {i[15:0], ~i[15:0]}; // Every word differs
	end

	// Outside the ROM reads as a nop
	assign romIndex = (instAddr - resetPc) >> 2;
	assign instData = (romIndex < romWords) ? rom[romIndex] : '0;

	assign dataRdata = ram[dataAddr[11:2]];

	always @(posedge clk) begin
		if (dataWe)
			ram[dataAddr[11:2]] <= dataWdata;
	end

endmodule

//--- testbench/mipsCoreTb.sv
`timescale 1ns/1ps

module mipsCoreTb;
	import isaPkg::*;

	logic clk;
	logic reset;
	logic [31:0] instAddr, instData, dataAddr, dataWdata, dataRdata;
	logic dataWe, grfWe;
	logic [4:0] grfAddr;
	logic [31:0] grfWdata, wbPc;

	logic [31:0] wbAddrQ[$], wbDataQ[$], wbPcQ[$];
	logic [31:0] memAddrQ[$], memDataQ[$];

	mipsCore i_mipsCore (.*);

	memModel i_memModel (.clk, .instAddr, .instData, .dataAddr, .dataWdata, .dataWe, .dataRdata);

	always #10 clk = ~clk;

	//////////////////////////////////////////////////
	// Instruction assembly
	function automatic logic [31:0] encodeR(logic [5:0] fn, int rd, int rs, int rt);
		return {opRtype, rs[4:0], rt[4:0], rd[4:0], 5'd0, fn};
	endfunction

	function automatic logic [31:0] encodeI(logic [5:0] op, int rt, int rs, logic [15:0] imm);
		return {op, rs[4:0], rt[4:0], imm};
	endfunction

	function automatic logic [31:0] encodeJal(logic [31:0] target);
		return {opJal, target[27:2]};
	endfunction

	function automatic logic [31:0] pcOf(int k);
		return 32'h3000 + 4 * k;
	endfunction

	//////////////////////////////////////////////////
	// Checks
	task automatic stopWith(input string msg);
		$display("%s", msg);
		$display("FAIL: see errors above");
		$fatal(1, "Simulation stopped");
	endtask

	task automatic check(input string name, input logic [31:0] expected, input logic [31:0] actual);
		if (expected !== actual) begin
			$display("FAILED %s: expected %h, actual %h", name, expected, actual);
			$display("FAIL: see errors above");
			$fatal(1, "Mismatch");
		end
	endtask

	task automatic place(input int k, input logic [31:0] word);
		i_memModel.rom[k] = word;
	endtask

	task automatic expectWb(input int rd, input logic [31:0] value, input logic [31:0] pc);
		wbAddrQ.push_back(rd);
		wbDataQ.push_back(value);
		wbPcQ.push_back(pc);
	endtask

	task automatic expectStore(input logic [31:0] addr, input logic [31:0] data);
		memAddrQ.push_back(addr);
		memDataQ.push_back(data);
	endtask

	// Clear the ROM and hold the core in reset while a program is placed
	task automatic startProgram();
		@(posedge clk);
		reset <= 1'b1;
		for (int i = 0; i < 256; i++)
			i_memModel.rom[i] = '0;
		wbAddrQ.delete();
		wbDataQ.delete();
		wbPcQ.delete();
		memAddrQ.delete();
		memDataQ.delete();
	endtask

	task automatic runProgram(input string name);
		int idle;
		repeat (3) @(posedge clk);
		reset <= 1'b0;
		idle = 0;
		while (wbAddrQ.size() > 0 || memAddrQ.size() > 0 || idle < 12) begin
			@(negedge clk);
			idle++;
			if (grfWe) begin
				if (wbAddrQ.size() == 0)
					stopWith($sformatf("Unexpected writeback to r%0d in %s", grfAddr, name));
				check({name, " grfAddr"}, wbAddrQ.pop_front(), grfAddr);
				check({name, " grfWdata"}, wbDataQ.pop_front(), grfWdata);
				check({name, " wbPc"}, wbPcQ.pop_front(), wbPc);
				idle = 0;
			end
			if (dataWe) begin
				if (memAddrQ.size() == 0)
					stopWith($sformatf("Unexpected store in %s", name));
				check({name, " dataAddr"}, memAddrQ.pop_front(), dataAddr);
				check({name, " dataWdata"}, memDataQ.pop_front(), dataWdata);
				idle = 0;
			end
			if (idle > 40)
				stopWith($sformatf("Timeout in %s: no writeback arrived", name));
		end
	endtask

	//////////////////////////////////////////////////
	// Directed tests
	task automatic testReset();
		repeat (2) begin
			@(negedge clk);
			check("reset instAddr", 32'h3000, instAddr);
			check("reset grfWe", 0, grfWe);
			check("reset dataWe", 0, dataWe);
		end
		@(posedge clk);
		reset <= 1'b0;
		@(negedge clk);
		check("after reset instAddr", 32'h3000, instAddr);
		check("after reset grfWe", 0, grfWe);
		check("after reset dataWe", 0, dataWe);
	endtask

	task automatic testAluChain();
		logic [31:0] r1, r2, r3, r4, r5, r6, r7, r8, r9;
		startProgram();
		r1 = 32'h8000_0000;
		place(0, encodeI(opLui, 1, 0, 16'h8000));
		expectWb(1, r1, pcOf(0));
		r1 = r1 | 32'h5;
		place(1, encodeI(opOri, 1, 1, 16'h0005));
		expectWb(1, r1, pcOf(1));
		r2 = r1 + 32'hffff_ffff; // addi -1
		place(2, encodeI(opAddi, 2, 1, 16'hffff));
		expectWb(2, r2, pcOf(2));
		r3 = r2 + r1; // Wraps past 2**32
		place(3, encodeR(fnAdd, 3, 2, 1));
		expectWb(3, r3, pcOf(3));
		r4 = r3 - r2;
		place(4, encodeR(fnSub, 4, 3, 2));
		expectWb(4, r4, pcOf(4));
		r5 = r4 & r1;
		place(5, encodeR(fnAnd, 5, 4, 1));
		expectWb(5, r5, pcOf(5));
		r6 = r5 | r3;
		place(6, encodeR(fnOr, 6, 5, 3));
		expectWb(6, r6, pcOf(6));
		r7 = ($signed(r6) < $signed(r3)) ? 32'd1 : 32'd0;
		place(7, encodeR(fnSlt, 7, 6, 3));
		expectWb(7, r7, pcOf(7));
		r8 = (r6 < r7) ? 32'd1 : 32'd0;
		place(8, encodeR(fnSltu, 8, 6, 7));
		expectWb(8, r8, pcOf(8));
		r9 = r6 & 32'h0000_ff0f;
		place(9, encodeI(opAndi, 9, 6, 16'hff0f));
		expectWb(9, r9, pcOf(9));
		runProgram("aluChain");
	endtask

	task automatic testMemory();
		startProgram();
		place(0, encodeI(opLui, 1, 0, 16'h1234));
		expectWb(1, 32'h1234_0000, pcOf(0));
		place(1, encodeI(opOri, 1, 1, 16'h5678));
		expectWb(1, 32'h1234_5678, pcOf(1));
		place(2, encodeI(opAddi, 2, 0, 16'h0040));
		expectWb(2, 32'h40, pcOf(2));
		place(3, encodeI(opSw, 1, 2, 16'h0004));
		expectStore(32'h44, 32'h1234_5678);
		place(4, encodeI(opLw, 3, 2, 16'h0004));
		expectWb(3, 32'h1234_5678, pcOf(4));
		place(5, encodeR(fnAdd, 4, 3, 1)); // Load-use
		expectWb(4, 32'h2468_acf0, pcOf(5));
		runProgram("memory");
	endtask

	task automatic testControl();
		startProgram();
		place(0, encodeI(opAddi, 1, 0, 16'd5));
		place(1, encodeI(opAddi, 2, 0, 16'd5));
		place(2, encodeI(opBeq, 2, 1, 16'd2)); // Taken to 5
		place(3, encodeI(opAddi, 3, 0, 16'd1));
		place(4, encodeI(opAddi, 4, 0, 16'd99)); // Skipped
		place(5, encodeI(opBne, 2, 1, 16'd5)); // Not taken
		place(6, encodeI(opAddi, 5, 0, 16'd2));
		place(7, encodeI(opBeq, 0, 1, 16'd5)); // Not taken
		place(8, encodeI(opAddi, 6, 0, 16'd3));
		place(9, encodeI(opBne, 0, 1, 16'd2)); // Taken to 12
		place(10, encodeI(opAddi, 7, 0, 16'd4));
		place(11, encodeI(opAddi, 8, 0, 16'd99)); // Skipped
		place(12, encodeJal(pcOf(20)));
		place(13, encodeI(opAddi, 9, 0, 16'd6));
		place(14, encodeI(opAddi, 10, 0, 16'd7));
		place(15, encodeI(opBeq, 0, 0, 16'hffff)); // Spin here on nops
		place(20, encodeI(opAddi, 11, 0, 16'd8));
		place(21, encodeR(fnJr, 0, 31, 0));
		place(22, encodeI(opAddi, 12, 0, 16'd9));
		expectWb(1, 5, pcOf(0));
		expectWb(2, 5, pcOf(1));
		expectWb(3, 1, pcOf(3));
		expectWb(5, 2, pcOf(6));
		expectWb(6, 3, pcOf(8));
		expectWb(7, 4, pcOf(10));
		expectWb(31, pcOf(14), pcOf(12));
		expectWb(9, 6, pcOf(13));
		expectWb(11, 8, pcOf(20));
		expectWb(12, 9, pcOf(22));
		expectWb(10, 7, pcOf(14));
		runProgram("control");
	endtask

	task automatic testRandom(input int iter);
		logic [31:0] a, b;
		a = $urandom;
		b = $urandom;
		startProgram();
		place(0, encodeI(opLui, 1, 0, a[31:16]));
		expectWb(1, {a[31:16], 16'h0}, pcOf(0));
		place(1, encodeI(opOri, 1, 1, a[15:0]));
		expectWb(1, a, pcOf(1));
		place(2, encodeI(opLui, 2, 0, b[31:16]));
		expectWb(2, {b[31:16], 16'h0}, pcOf(2));
		place(3, encodeI(opOri, 2, 2, b[15:0]));
		expectWb(2, b, pcOf(3));
		place(4, encodeR(fnAdd, 3, 1, 2));
		expectWb(3, a + b, pcOf(4));
		place(5, encodeR(fnSub, 4, 1, 2));
		expectWb(4, a - b, pcOf(5));
		place(6, encodeR(fnAnd, 5, 1, 2));
		expectWb(5, a & b, pcOf(6));
		place(7, encodeR(fnOr, 6, 1, 2));
		expectWb(6, a | b, pcOf(7));
		place(8, encodeR(fnSlt, 7, 1, 2));
		expectWb(7, ($signed(a) < $signed(b)) ? 32'd1 : 32'd0, pcOf(8));
		place(9, encodeR(fnSltu, 8, 1, 2));
		expectWb(8, (a < b) ? 32'd1 : 32'd0, pcOf(9));
		runProgram($sformatf("random%0d", iter));
	endtask

	initial begin
		clk = 1'b0;
		reset = 1'b1;
		void'($urandom(32'hc115_1215));
		testReset();
		testAluChain();
		testMemory();
		testControl();
		for (int i = 0; i < 4; i++)
			testRandom(i);
		$display("PASS: all tests");
		$finish;
	end

endmodule

//--- flist.f
verilog/isaPkg.sv
verilog/pipePkg.sv
verilog/stageIf.sv
verilog/regFile.sv
verilog/decodeStage.sv
verilog/executeStage.sv
verilog/resultStage.sv
verilog/mipsCore.sv
testbench/memModel.sv
testbench/mipsCoreTb.sv

//--- Bender.yml
package:
  name: mipsCore

sources:
  - verilog/isaPkg.sv
  - verilog/pipePkg.sv
  - verilog/stageIf.sv
  - verilog/regFile.sv
  - verilog/decodeStage.sv
  - verilog/executeStage.sv
  - verilog/resultStage.sv
  - verilog/mipsCore.sv
  - target: simulation
    files:
      - testbench/memModel.sv
      - testbench/mipsCoreTb.sv
